// File: sysarr_types_pkg.sv
package sysarr_types_pkg;

    // element and accumulator widths of the matrix engine
    localparam int DATA_W = 8;
    localparam int ACC_W  = 24;

    // one signed matrix element, as carried in input and weight rows
    typedef logic signed [DATA_W-1:0] elem_t;

    // one signed accumulator lane of a product, partial or output row
    typedef logic signed [ACC_W-1:0] acc_t;

    // rows travel as flat words of N lanes, lane j at [j*W +: W]
    // their width depends on the module parameter N, so the row types
    // appear as port widths in each module and not here

endpackage

// File: sysarr_ctrl_pkg.sv
package sysarr_ctrl_pkg;

    localparam int SLOTS = 3; // GEMMs the control unit can track at once

    typedef logic [SLOTS-1:0]         slot_mask_t; // one bit per occupied slot
    typedef logic [$clog2(SLOTS)-1:0] slot_idx_t;

    // index of the lowest set bit, zero when the mask is empty
    function automatic slot_idx_t first_set(input slot_mask_t m);
        slot_idx_t idx;
        idx = '0;
        for (int s = SLOTS - 1; s >= 0; s--) begin
            if (m[s]) begin
                idx = slot_idx_t'(s);
            end
        end
        return idx;
    endfunction

endpackage

// File: sysarr_cu_if.sv
`timescale 1ns/10ps

interface sysarr_cu_if #(
    parameter int N       = 4,
    parameter int MUL_LEN = 2,
    parameter int ADD_LEN = 2
);
    localparam int ROW_W = $clog2(N);

    logic             input_load;    // input row write into the buffers
    logic [ROW_W-1:0] input_row;
    logic             weight_load;   // weight row write into the MAC array
    logic [ROW_W-1:0] weight_row;
    logic             partials_load; // partial row write into the buffers
    logic [ROW_W-1:0] partials_row;
    logic             ps_bank;       // bank set the partial write goes to
    logic             MAC_start;
    logic [ROW_W-1:0] rd_row;        // row consumed by the current MAC step
    logic             rd_bank;
    logic             add_start;

    // the datapath is only sized and timed for this range
    if (N < 2 || N > 8 || MUL_LEN < 1 || MUL_LEN > 4 || ADD_LEN < 1 || ADD_LEN > 3)
    begin : g_param_check
        $error("sysarr_cu_if: N, MUL_LEN or ADD_LEN out of supported range");
    end

    modport control_unit (
        output input_load, input_row, weight_load, weight_row,
        output partials_load, partials_row, ps_bank,
        output MAC_start, rd_row, rd_bank, add_start
    );
    modport buffers (
        input input_load, input_row, partials_load, partials_row, ps_bank, rd_row, rd_bank
    );
    modport mac (input weight_load, weight_row, MAC_start);
    modport adder (input add_start);
endinterface

// File: sysarr_control_unit.sv
`timescale 1ns/10ps

module sysarr_control_unit import sysarr_ctrl_pkg::*; #(
    parameter int N       = 4,
    parameter int MUL_LEN = 2
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 input_en,
    input  logic                 weight_en,
    input  logic                 partial_en,
    input  logic [$clog2(N)-1:0] row_in_en,
    input  logic [$clog2(N)-1:0] row_ps_en,
    output logic                 fifo_has_space,
    sysarr_cu_if.control_unit    cu
);
    localparam int ROW_W = $clog2(N);

    slot_mask_t       occ, nxt_occ;
    logic [ROW_W-1:0] iter [SLOTS];     // next row each slot will issue
    logic [ROW_W-1:0] nxt_iter [SLOTS];
    slot_idx_t        oldest, nxt_oldest;
    logic             next_bank;        // bank set the next GEMM loads into
    logic             old_bank;         // bank set of the oldest GEMM
    logic             ps_bank_q;
    logic [N-1:0]     in_loaded [2];    // per bank set, rows written so far
    logic [N-1:0]     ps_loaded [2];
    logic [N-1:0]     ps_bit;
    logic             in_bank, ps_fill;
    logic             start, issue, retire, inputs_pending;
    logic [ROW_W-1:0] cur_row;
    logic [MUL_LEN-1:0] add_sr;

    // input_en wins the shared row_in_en bus over weight_en
    always_comb begin
        cu.input_load    = 1'b0;
        cu.input_row     = '0;
        cu.weight_load   = 1'b0;
        cu.weight_row    = '0;
        cu.partials_load = 1'b0;
        cu.partials_row  = '0;
        if (input_en) begin
            cu.input_load = 1'b1;
            cu.input_row  = row_in_en;
        end else if (weight_en) begin
            cu.weight_load = 1'b1;
            cu.weight_row  = row_in_en;
        end
        if (partial_en) begin
            cu.partials_load = 1'b1;
            cu.partials_row  = row_ps_en;
        end
    end

    assign start   = cu.input_load && (cu.input_row == '0);
    assign in_bank = (cu.input_row == '0) ? next_bank : ~next_bank; // row 0 opens a new bank set
    assign ps_bit  = N'(1) << cu.partials_row;
    assign ps_fill = cu.partials_load && (&(ps_loaded[ps_bank_q] | ps_bit));
    assign cu.ps_bank = ps_bank_q;

    // only the oldest GEMM issues, one whole row per MAC step
    assign cur_row = iter[oldest];
    assign issue   = in_loaded[old_bank][cur_row] && ps_loaded[old_bank][cur_row];
    assign retire  = issue && (cur_row == ROW_W'(N - 1));

    always_comb begin
        nxt_occ    = occ;
        nxt_iter   = iter;
        nxt_oldest = oldest;
        if (issue) begin
            nxt_iter[oldest] = cur_row + 1'b1;
            if (retire) begin
                nxt_iter[oldest] = '0;
                nxt_occ[oldest]  = 1'b0; // last row issued so the slot is free again
            end
        end
        if (start) begin
            nxt_occ[first_set(~occ)] = 1'b1;
        end
        if (retire || occ == '0) begin
            nxt_oldest = first_set(nxt_occ); // at most one slot left here
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            occ          <= '0;
            iter         <= '{default: '0};
            oldest       <= '0;
            next_bank    <= 1'b0;
            old_bank     <= 1'b0;
            ps_bank_q    <= 1'b0;
            in_loaded    <= '{default: '0};
            ps_loaded    <= '{default: '0};
            cu.MAC_start <= 1'b0;
            cu.rd_row    <= '0;
            cu.rd_bank   <= 1'b0;
        end else begin
            occ    <= nxt_occ;
            iter   <= nxt_iter;
            oldest <= nxt_oldest;
            if (start) begin
                next_bank <= ~next_bank;
            end
            if (ps_fill) begin
                ps_bank_q <= ~ps_bank_q; // later partials belong to the next GEMM
            end
            if (retire) begin
                old_bank            <= ~old_bank;
                in_loaded[old_bank] <= '0;
                ps_loaded[old_bank] <= '0;
            end
            if (cu.input_load) begin
                in_loaded[in_bank][cu.input_row] <= 1'b1;
            end
            if (cu.partials_load) begin
                ps_loaded[ps_bank_q][cu.partials_row] <= 1'b1;
            end
            cu.MAC_start <= issue;
            if (issue) begin
                cu.rd_row  <= cur_row;
                cu.rd_bank <= old_bank;
            end
        end
    end

    // products leave the multiply pipeline MUL_LEN cycles after MAC_start
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            add_sr <= '0;
        end else begin
            add_sr <= (add_sr << 1) | MUL_LEN'(cu.MAC_start);
        end
    end
    assign cu.add_start = add_sr[MUL_LEN-1];

    // with two buffer bank sets a new GEMM may only join a single older one
    assign inputs_pending = (occ != '0) && !(&in_loaded[~next_bank]);
    assign fifo_has_space = !inputs_pending && ($countones(occ) < 2);

    a_row0_needs_space: assert property (@(posedge clk) disable iff (!nRST)
        (input_en && row_in_en == '0) |-> fifo_has_space)
        else $error("input row 0 loaded while fifo_has_space is low");

    a_start_needs_slot: assert property (@(posedge clk) disable iff (!nRST)
        cu.MAC_start |-> $past(occ[oldest]))
        else $error("MAC_start issued with no occupied slot");
endmodule

// File: sysarr_row_buffers.sv
`timescale 1ns/10ps

module sysarr_row_buffers import sysarr_types_pkg::*; #(
    parameter int N = 4
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [N*DATA_W-1:0]  row_data,
    input  logic [N*ACC_W-1:0]   ps_data,
    sysarr_cu_if.buffers         cu,
    output logic [N*DATA_W-1:0]  in_row,
    output logic [N*ACC_W-1:0]   ps_row
);
    logic [N*DATA_W-1:0] in_mem [2][N]; // two bank sets so one GEMM loads while another reads
    logic [N*ACC_W-1:0]  ps_mem [2][N];
    logic                in_bank_q;      // bank set of the GEMM currently loading inputs
    logic                in_wr_bank;

    // row 0 of an input starts a new GEMM in the other bank set
    assign in_wr_bank = (cu.input_row == '0) ? ~in_bank_q : in_bank_q;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            in_bank_q <= 1'b1; // so the first GEMM lands in bank set 0
        end else if (cu.input_load && cu.input_row == '0) begin
            in_bank_q <= ~in_bank_q;
        end
    end

    always_ff @(posedge clk) begin
        if (cu.input_load) begin
            in_mem[in_wr_bank][cu.input_row] <= row_data;
        end
        if (cu.partials_load) begin
            ps_mem[cu.ps_bank][cu.partials_row] <= ps_data;
        end
    end

    // read during the MAC_start cycle, consumed by the array and the adder
    assign in_row = in_mem[cu.rd_bank][cu.rd_row];
    assign ps_row = ps_mem[cu.rd_bank][cu.rd_row];
endmodule

// File: sysarr_mac_array.sv
`timescale 1ns/10ps

module sysarr_mac_array import sysarr_types_pkg::*; #(
    parameter int N       = 4,
    parameter int MUL_LEN = 2
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [N*DATA_W-1:0]  row_data,
    input  logic [N*DATA_W-1:0]  in_row,
    sysarr_cu_if.mac             cu,
    output logic [N*ACC_W-1:0]   prod_row
);
    elem_t w [N][N];        // w[k][j] multiplies input lane k into output lane j
    elem_t in_e [N];
    acc_t  sums [N];
    acc_t  pipe [MUL_LEN][N];

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            w <= '{default: '0};
        end else if (cu.weight_load) begin
            for (int j = 0; j < N; j++) begin
                w[cu.weight_row][j] <= row_data[j*DATA_W +: DATA_W];
            end
        end
    end

    // whole row times the weight matrix in one step
    always_comb begin
        acc_t acc;
        for (int k = 0; k < N; k++) begin
            in_e[k] = in_row[k*DATA_W +: DATA_W];
        end
        for (int j = 0; j < N; j++) begin
            acc = '0;
            for (int k = 0; k < N; k++) begin
                acc = acc + acc_t'(in_e[k]) * acc_t'(w[k][j]); // sign extended before the multiply
            end
            sums[j] = acc;
        end
    end

    always_ff @(posedge clk) begin
        if (cu.MAC_start) begin
            pipe[0] <= sums;
        end
        for (int s = 1; s < MUL_LEN; s++) begin
            pipe[s] <= pipe[s-1]; // several rows can be in flight here
        end
    end

    always_comb begin
        for (int j = 0; j < N; j++) begin
            prod_row[j*ACC_W +: ACC_W] = pipe[MUL_LEN-1][j];
        end
    end

    a_no_weight_write_on_mac: assert property (@(posedge clk) disable iff (!nRST)
        cu.weight_load |-> !cu.MAC_start)
        else $error("weight row written in the same cycle as MAC_start");
endmodule

// File: sysarr_partial_adder.sv
`timescale 1ns/10ps

module sysarr_partial_adder import sysarr_types_pkg::*; #(
    parameter int N       = 4,
    parameter int MUL_LEN = 2,
    parameter int ADD_LEN = 2
) (
    input  logic                clk,
    input  logic                nRST,
    input  logic [N*ACC_W-1:0]  prod_row,
    input  logic [N*ACC_W-1:0]  ps_row,
    sysarr_cu_if.adder          cu,
    output logic                out_valid,
    output logic [N*ACC_W-1:0]  out_data
);
    logic [N*ACC_W-1:0] ps_dly [MUL_LEN]; // partial row following its product
    logic [N*ACC_W-1:0] sum_row;
    logic [N*ACC_W-1:0] stage [ADD_LEN];
    logic [ADD_LEN-1:0] vld;

    always_comb begin
        for (int j = 0; j < N; j++) begin
            sum_row[j*ACC_W +: ACC_W] = acc_t'(prod_row[j*ACC_W +: ACC_W])
                                      + acc_t'(ps_dly[MUL_LEN-1][j*ACC_W +: ACC_W]);
        end
    end

    // ps_row sampled in the MAC_start cycle reaches the end in the add_start cycle
    always_ff @(posedge clk) begin
        ps_dly[0] <= ps_row;
        for (int s = 1; s < MUL_LEN; s++) begin
            ps_dly[s] <= ps_dly[s-1];
        end
        if (cu.add_start) begin
            stage[0] <= sum_row;
        end
        for (int s = 1; s < ADD_LEN; s++) begin
            stage[s] <= stage[s-1];
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            vld <= '0;
        end else begin
            vld <= (vld << 1) | ADD_LEN'(cu.add_start);
        end
    end

    assign out_valid = vld[ADD_LEN-1];
    assign out_data  = stage[ADD_LEN-1]; // last stage doubles as the output row register
endmodule

// File: sysarr_top.sv
`timescale 1ns/10ps

module sysarr_top import sysarr_types_pkg::*; #(
    parameter int N       = 4,
    parameter int MUL_LEN = 2,
    parameter int ADD_LEN = 2
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 input_en,
    input  logic                 weight_en,
    input  logic                 partial_en,
    input  logic [$clog2(N)-1:0] row_in_en,
    input  logic [$clog2(N)-1:0] row_ps_en,
    input  logic [N*DATA_W-1:0]  row_data,
    input  logic [N*ACC_W-1:0]   ps_data,
    output logic                 fifo_has_space,
    output logic                 out_valid,
    output logic [N*ACC_W-1:0]   out_data
);
    logic [N*DATA_W-1:0] in_row;
    logic [N*ACC_W-1:0]  ps_row;
    logic [N*ACC_W-1:0]  prod_row;

    sysarr_cu_if #(.N(N), .MUL_LEN(MUL_LEN), .ADD_LEN(ADD_LEN)) cu_if ();

    sysarr_control_unit #(.N(N), .MUL_LEN(MUL_LEN)) u_cu (
        .clk, .nRST, .input_en, .weight_en, .partial_en, .row_in_en, .row_ps_en,
        .fifo_has_space, .cu(cu_if.control_unit)
    );

    sysarr_row_buffers #(.N(N)) u_buf (
        .clk, .nRST, .row_data, .ps_data, .cu(cu_if.buffers), .in_row, .ps_row
    );

    sysarr_mac_array #(.N(N), .MUL_LEN(MUL_LEN)) u_mac (
        .clk, .nRST, .row_data, .in_row, .cu(cu_if.mac), .prod_row
    );

    sysarr_partial_adder #(.N(N), .MUL_LEN(MUL_LEN), .ADD_LEN(ADD_LEN)) u_add (
        .clk, .nRST, .prod_row, .ps_row, .cu(cu_if.adder), .out_valid, .out_data
    );
endmodule

// File: tb_sysarr.sv
`timescale 1ns/10ps

module tb_sysarr import sysarr_types_pkg::*; #(
    parameter int N       = 4,
    parameter int MUL_LEN = 2,
    parameter int ADD_LEN = 2
);
    localparam int RW        = $clog2(N);
    localparam int MAX_G     = 5;                  // GEMMs in one batch
    localparam int MAX_IDS   = 16;                 // GEMMs over the whole run
    localparam int ROWS_SENT = 3 * N + 13 * 2 * N; // three weight sets, 13 GEMMs of inputs and partials
    localparam int LIMIT     = 40 * ROWS_SENT + 200;

    logic                clk = 1'b0;
    logic                nRST;
    logic                input_en, weight_en, partial_en;
    logic [RW-1:0]       row_in_en, row_ps_en;
    logic [N*DATA_W-1:0] row_data;
    logic [N*ACC_W-1:0]  ps_data;
    logic                fifo_has_space, out_valid;
    logic [N*ACC_W-1:0]  out_data;

    int                  w_model [N][N];  // w_model[k][j] takes input lane k to output lane j
    logic [N*DATA_W-1:0] in_vec [MAX_G][N];
    logic [N*ACC_W-1:0]  ps_vec [MAX_G][N];
    logic [N*ACC_W-1:0]  exp_q [$];
    int                  exp_id_q [$];     // gemm id times N plus row
    bit                  ps_sent [MAX_IDS*N];
    int                  gemm_base;
    int                  cycles = 0;
    string               test_name;

    sysarr_top #(.N(N), .MUL_LEN(MUL_LEN), .ADD_LEN(ADD_LEN)) dut0 (
        .clk, .nRST, .input_en, .weight_en, .partial_en, .row_in_en, .row_ps_en,
        .row_data, .ps_data, .fifo_has_space, .out_valid, .out_data
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at cycle %0d", cycles);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles, rows are still missing", LIMIT));
        end
    end

    // all DUT signals read here were settled before this edge
    always @(posedge clk) begin
        logic [N*ACC_W-1:0] want;
        int                 id;
        if (input_en && row_in_en == '0) begin
            assert (fifo_has_space === 1'b1)
                else abort_run("input row 0 reached the DUT while fifo_has_space was low");
        end
        if (out_valid === 1'b1) begin
            assert (exp_q.size() > 0) else abort_run("out_valid rose with no row expected");
            want = exp_q.pop_front();
            id   = exp_id_q.pop_front();
            assert (ps_sent[id])
                else abort_run($sformatf("gemm %0d row %0d came out before its partial row",
                                         id / N, id % N));
            assert (out_data === want) else begin
                $display("MISMATCH %s gemm %0d row %0d: expected %h, actual %h",
                         test_name, id / N, id % N, want, out_data);
                abort_run("output row differs from the model");
            end
        end
    end

    task automatic load_weights(input bit extreme);
        logic [N*DATA_W-1:0] v;
        int                  a;
        for (int k = 0; k < N; k++) begin
            for (int j = 0; j < N; j++) begin
                a = extreme ? (($urandom % 2) ? 127 : -128) : int'($urandom_range(255)) - 128;
                w_model[k][j] = a;
                v[j*DATA_W +: DATA_W] = a[DATA_W-1:0];
            end
            @(posedge clk);
            weight_en <= 1'b1;
            row_in_en <= RW'(k);
            row_data  <= v;
        end
        @(posedge clk);
        weight_en <= 1'b0;
    endtask

    // expected row r is input row r times the weights plus partial row r
    task automatic gen_gemm(input int g, input bit extreme);
        logic [N*ACC_W-1:0] want;
        longint             acc;
        int                 a;
        for (int r = 0; r < N; r++) begin
            for (int k = 0; k < N; k++) begin
                a = extreme ? (($urandom % 2) ? 127 : -128) : int'($urandom_range(255)) - 128;
                in_vec[g][r][k*DATA_W +: DATA_W] = a[DATA_W-1:0];
            end
            for (int j = 0; j < N; j++) begin
                a = extreme ? (($urandom % 2) ? (1 << 22) - 1 : -(1 << 22))
                            : int'($urandom_range(1 << 20)) - (1 << 19);
                ps_vec[g][r][j*ACC_W +: ACC_W] = a[ACC_W-1:0];
                acc = a;
                for (int k = 0; k < N; k++) begin
                    acc += longint'($signed(in_vec[g][r][k*DATA_W +: DATA_W])) * w_model[k][j];
                end
                assert (acc >= -(64'sd1 << (ACC_W - 1)) && acc < (64'sd1 << (ACC_W - 1)))
                    else abort_run("test data would overflow the accumulator width");
                want[j*ACC_W +: ACC_W] = acc[ACC_W-1:0];
            end
            exp_q.push_back(want);
            exp_id_q.push_back((gemm_base + g) * N + r);
        end
    endtask

    // mode 0 back to back, mode 1 partials late and shuffled, mode 2 random overlap
    task automatic run_batch(input int ng, input int mode);
        int in_g, in_r, ps_g, ps_cnt, n_cand, pick;
        int cand [N];
        bit done_ps [N];
        bit send_in;
        in_g    = 0;
        in_r    = 0;
        ps_g    = 0;
        ps_cnt  = 0;
        done_ps = '{default: 1'b0};
        while (ps_g < ng) begin
            @(posedge clk);
            send_in = (in_g < ng) && (mode != 2 || $urandom_range(1) == 1);
            if (in_r == 0) begin
                send_in = send_in && fifo_has_space; // a new GEMM needs room in the DUT
            end
            n_cand = 0;
            for (int r = 0; r < N; r++) begin
                if (!done_ps[r] && (ps_g < in_g || r < in_r)) begin
                    cand[n_cand] = r; // its input row went out on an earlier cycle
                    n_cand++;
                end
            end
            if ((mode == 1 && in_g < ng) || (mode != 0 && $urandom_range(2) == 0)) begin
                n_cand = 0;
            end
            input_en   <= send_in;
            partial_en <= (n_cand > 0);
            if (send_in) begin
                row_in_en <= RW'(in_r);
                row_data  <= in_vec[in_g][in_r];
                in_r++;
                if (in_r == N) begin
                    in_r = 0;
                    in_g++;
                end
            end
            if (n_cand > 0) begin
                pick = (mode == 0) ? cand[0] : cand[$urandom_range(n_cand - 1)];
                row_ps_en <= RW'(pick);
                ps_data   <= ps_vec[ps_g][pick];
                ps_sent[(gemm_base + ps_g) * N + pick] <= 1'b1;
                done_ps[pick] = 1'b1;
                ps_cnt++;
                if (ps_cnt == N) begin
                    ps_g++;
                    ps_cnt  = 0;
                    done_ps = '{default: 1'b0};
                end
            end
        end
        @(posedge clk);
        input_en   <= 1'b0;
        partial_en <= 1'b0;
        gemm_base += ng;
    endtask

    task automatic run_test(input string name, input int ng, input int mode, input bit extreme);
        test_name = name;
        for (int g = 0; g < ng; g++) begin
            gen_gemm(g, extreme);
        end
        run_batch(ng, mode);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        void'($urandom(32'h514e_eefb));
        nRST       = 1'b0;
        input_en   = 1'b0;
        weight_en  = 1'b0;
        partial_en = 1'b0;
        row_in_en  = '0;
        row_ps_en  = '0;
        row_data   = '0;
        ps_data    = '0;
        gemm_base  = 0;
        test_name  = "idle_after_reset";
        repeat (3) @(posedge clk);
        nRST <= 1'b1;
        repeat (5) begin
            @(posedge clk);
            assert (out_valid === 1'b0 && fifo_has_space === 1'b1) else begin
                $display("MISMATCH %s: expected out_valid 0 fifo_has_space 1, actual %b %b",
                         test_name, out_valid, fifo_has_space);
                abort_run("DUT is not idle after reset");
            end
        end
        load_weights(1'b0);
        run_test("single_gemm", 1, 0, 1'b0);
        run_test("late_partials", 1, 1, 1'b0);
        run_test("overlap", 5, 2, 1'b0);
        load_weights(1'b0);                        // only GEMMs from here on see the new weights
        run_test("weight_reload", 4, 2, 1'b0);
        load_weights(1'b1);
        run_test("signed_extremes", 2, 2, 1'b1);
        repeat (MUL_LEN + ADD_LEN + 4) @(posedge clk); // a stray out_valid would hit the checker
        assert (fifo_has_space === 1'b1) else begin
            $display("MISMATCH %s: expected fifo_has_space 1 once all rows are out, actual %b",
                     test_name, fifo_has_space);
            abort_run("DUT kept a slot occupied after its last row");
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end
endmodule

// File: compile.f
sysarr_types_pkg.sv
sysarr_ctrl_pkg.sv
sysarr_cu_if.sv
sysarr_control_unit.sv
sysarr_row_buffers.sv
sysarr_mac_array.sv
sysarr_partial_adder.sv
sysarr_top.sv
tb_sysarr.sv

// File: Bender.yml
package:
  name: sysarr

sources:
  - sysarr_types_pkg.sv
  - sysarr_ctrl_pkg.sv
  - sysarr_cu_if.sv
  - sysarr_control_unit.sv
  - sysarr_row_buffers.sv
  - sysarr_mac_array.sv
  - sysarr_partial_adder.sv
  - sysarr_top.sv
  - target: test
    files:
      - tb_sysarr.sv
